// File: rtl/shell_pkg.sv
/* Widths, register map and port indices shared by the memory shell
   Register offsets are byte addresses on the 32-bit register port
   WORD_COUNT holds up to twice the memory depth */
package shell_pkg;

  // ----------------------------------------------------------------------
  // Data path and memory
  // ----------------------------------------------------------------------
  localparam int DATA_W     = 32;
  localparam int ADDR_W     = 10;
  localparam int MEM_WORDS  = 1 << ADDR_W;
  localparam int CNT_W      = ADDR_W + 1;

  // ----------------------------------------------------------------------
  // Register path
  // ----------------------------------------------------------------------
  localparam int REG_ADDR_W      = 8;
  localparam int REG_PIPE_STAGES = 2;
  // wr, rd, addr, wdata
  localparam int REQ_PIPE_W      = 2 + REG_ADDR_W + DATA_W;
  // ack, rdata
  localparam int RSP_PIPE_W      = 1 + DATA_W;

  localparam logic [REG_ADDR_W-1:0] REG_CTRL       = 8'h00;
  localparam logic [REG_ADDR_W-1:0] REG_START_ADDR = 8'h04;
  localparam logic [REG_ADDR_W-1:0] REG_WORD_COUNT = 8'h08;
  localparam logic [REG_ADDR_W-1:0] REG_STATUS     = 8'h0C;
  localparam logic [REG_ADDR_W-1:0] REG_SUM_A      = 8'h10;
  localparam logic [REG_ADDR_W-1:0] REG_SUM_B      = 8'h14;

  localparam int CTRL_START_BIT  = 0;
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

  // Memory requesters
  localparam logic PORT_HOST   = 1'b0;
  localparam logic PORT_KERNEL = 1'b1;

endpackage

// File: rtl/cmd_pipe.sv
`timescale 1ns/1ps
/* Fixed-depth register pipeline for strobe bundles
   Every stage clears on reset so strobes come out low
   STAGES must be at least 1 */
module cmd_pipe #(
  parameter int WIDTH  = 8,
  parameter int STAGES = 2
) (
  input  logic             clk,
  input  logic             sync_rst_n,
  input  logic [WIDTH-1:0] in_bus,
  output logic [WIDTH-1:0] out_bus
);

  logic [WIDTH-1:0] stage_q [STAGES];

  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      for (int i = 0; i < STAGES; i++)
      begin
        stage_q[i] <= '0;
      end
    end
    else
    begin
      stage_q[0] <= in_bus;
      // Shift toward the output end
      for (int i = 1; i < STAGES; i++)
      begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign out_bus = stage_q[STAGES-1];

endmodule

// File: rtl/word_memory.sv
`timescale 1ns/1ps
/* Single-port synchronous word memory, one-cycle read latency
   Read data holds its last value across writes and idle cycles
   Contents are undefined until written */
module word_memory (
  input  logic                         clk,
  input  logic                         mem_en,
  input  logic                         mem_we,
  input  logic [shell_pkg::ADDR_W-1:0] mem_addr,
  input  logic [shell_pkg::DATA_W-1:0] mem_wdata,
  output logic [shell_pkg::DATA_W-1:0] mem_rdata
);
  import shell_pkg::*;

  logic [DATA_W-1:0] mem_array [MEM_WORDS];

  always_ff @(posedge clk)
  begin
    if (mem_en)
    begin
      if (mem_we)
      begin
        mem_array[mem_addr] <= mem_wdata;
      end
      else
      begin
        // Registered read port
        mem_rdata <= mem_array[mem_addr];
      end
    end
  end

endmodule

// File: rtl/mem_arbiter.sv
`timescale 1ns/1ps
/* Round-robin arbiter giving the memory to the host port or the kernel
   Grants are combinational from held requests; host wins first after reset
   Read data returns one cycle after the grant to the port that won it */
module mem_arbiter (
  input  logic                         clk,
  input  logic                         sync_rst_n,
  // Host side
  input  logic                         host_req,
  input  logic                         host_we,
  input  logic [shell_pkg::ADDR_W-1:0] host_addr,
  input  logic [shell_pkg::DATA_W-1:0] host_wdata,
  output logic                         host_gnt,
  output logic                         host_rvalid,
  output logic [shell_pkg::DATA_W-1:0] host_rdata,
  // Kernel side, read only
  input  logic                         kern_req,
  input  logic [shell_pkg::ADDR_W-1:0] kern_addr,
  output logic                         kern_gnt,
  output logic                         kern_rvalid,
  output logic [shell_pkg::DATA_W-1:0] kern_rdata,
  // Memory side
  output logic                         mem_en,
  output logic                         mem_we,
  output logic [shell_pkg::ADDR_W-1:0] mem_addr,
  output logic [shell_pkg::DATA_W-1:0] mem_wdata,
  input  logic [shell_pkg::DATA_W-1:0] mem_rdata
);
  import shell_pkg::*;

  logic last_gnt;
  logic host_rd_q;
  logic kern_rd_q;

  // ----------------------------------------------------------------------
  // Grant selection
  // ----------------------------------------------------------------------
  // Host wins unless the kernel is owed the turn
  assign host_gnt = host_req && (!kern_req || last_gnt == PORT_KERNEL);
  assign kern_gnt = kern_req && !host_gnt;

  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      last_gnt <= PORT_KERNEL;
    end
    else if (host_gnt)
    begin
      last_gnt <= PORT_HOST;
    end
    else if (kern_gnt)
    begin
      last_gnt <= PORT_KERNEL;
    end
  end

  // Memory command for the winner
  assign mem_en    = host_gnt || kern_gnt;
  assign mem_we    = host_gnt && host_we;
  assign mem_addr  = kern_gnt ? kern_addr : host_addr;
  assign mem_wdata = host_wdata;

  // ----------------------------------------------------------------------
  // Read return routing
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      host_rd_q <= 1'b0;
      kern_rd_q <= 1'b0;
    end
    else
    begin
      host_rd_q <= host_gnt && !host_we;
      kern_rd_q <= kern_gnt;
    end
  end

  assign host_rvalid = host_rd_q;
  assign kern_rvalid = kern_rd_q;
  assign host_rdata  = host_rd_q ? mem_rdata : '0;
  assign kern_rdata  = kern_rd_q ? mem_rdata : '0;

  a_one_grant: assert property (@(posedge clk) disable iff (!sync_rst_n)
    !(host_gnt && kern_gnt));

  a_gnt_with_req: assert property (@(posedge clk) disable iff (!sync_rst_n)
    (host_gnt |-> host_req) and (kern_gnt |-> kern_req));

  a_host_rvalid: assert property (@(posedge clk) disable iff (!sync_rst_n)
    host_rvalid |-> $past(host_gnt && !host_we));

  // A waiting kernel is served next when the host keeps asking
  a_round_robin: assert property (@(posedge clk) disable iff (!sync_rst_n)
    (host_gnt && kern_req) |=> (host_req && kern_req) |-> kern_gnt);

endmodule

// File: rtl/fletcher_kernel.sv
`timescale 1ns/1ps
/* Fletcher-style checksum kernel with its register file
   START_ADDR keeps ADDR_W bits and WORD_COUNT keeps CNT_W bits of a write
   Reads wrap at the end of memory; a start while busy is ignored */
module fletcher_kernel (
  input  logic                             clk,
  input  logic                             sync_rst_n,
  // Register port
  input  logic                             reg_wr,
  input  logic                             reg_rd,
  input  logic [shell_pkg::REG_ADDR_W-1:0] reg_addr,
  input  logic [shell_pkg::DATA_W-1:0]     reg_wdata,
  output logic                             reg_ack,
  output logic [shell_pkg::DATA_W-1:0]     reg_rdata,
  // Memory read port
  output logic                             kern_req,
  output logic [shell_pkg::ADDR_W-1:0]     kern_addr,
  input  logic                             kern_gnt,
  input  logic                             kern_rvalid,
  input  logic [shell_pkg::DATA_W-1:0]     kern_rdata
);
  import shell_pkg::*;

  logic [ADDR_W-1:0] start_addr;
  logic [CNT_W-1:0]  word_count;
  logic              busy;
  logic              done;
  logic              start;
  logic [ADDR_W-1:0] rd_addr;
  logic [CNT_W-1:0]  issue_left;
  logic [CNT_W-1:0]  recv_left;
  logic [DATA_W-1:0] sum_a;
  logic [DATA_W-1:0] sum_b;
  logic [DATA_W-1:0] sum_a_next;
  logic [DATA_W-1:0] rd_word;

  // ----------------------------------------------------------------------
  // Register file
  // ----------------------------------------------------------------------
  assign start = reg_wr && (reg_addr == REG_CTRL) && reg_wdata[CTRL_START_BIT] && !busy;

  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      start_addr <= '0;
      word_count <= '0;
    end
    else if (reg_wr)
    begin
      if (reg_addr == REG_START_ADDR)
      begin
        start_addr <= reg_wdata[ADDR_W-1:0];
      end
      if (reg_addr == REG_WORD_COUNT)
      begin
        word_count <= reg_wdata[CNT_W-1:0];
      end
    end
  end

  always_comb
  begin
    rd_word = '0;
    case (reg_addr)
      REG_START_ADDR: rd_word = DATA_W'(start_addr);
      REG_WORD_COUNT: rd_word = DATA_W'(word_count);
      REG_STATUS:
      begin
        rd_word[STATUS_BUSY_BIT] = busy;
        rd_word[STATUS_DONE_BIT] = done;
      end
      REG_SUM_A:      rd_word = sum_a;
      REG_SUM_B:      rd_word = sum_b;
      // CTRL and unmapped offsets read as zero
      default:        rd_word = '0;
    endcase
  end

  // Ack one cycle after the strobe, zero data on writes
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      reg_ack   <= 1'b0;
      reg_rdata <= '0;
    end
    else
    begin
      reg_ack   <= reg_wr || reg_rd;
      reg_rdata <= reg_rd ? rd_word : '0;
    end
  end

  // ----------------------------------------------------------------------
  // Read engine
  // ----------------------------------------------------------------------
  // Requests run ahead of returns; the arbiter keeps them in order
  assign kern_req   = busy && (issue_left != '0);
  assign kern_addr  = rd_addr;
  assign sum_a_next = sum_a + kern_rdata;

  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      busy       <= 1'b0;
      done       <= 1'b0;
      rd_addr    <= '0;
      issue_left <= '0;
      recv_left  <= '0;
      sum_a      <= '0;
      sum_b      <= '0;
    end
    else if (start)
    begin
      busy       <= 1'b1;
      done       <= 1'b0;
      rd_addr    <= start_addr;
      issue_left <= word_count;
      recv_left  <= word_count;
      sum_a      <= '0;
      sum_b      <= '0;
    end
    else if (busy)
    begin
      if (kern_gnt)
      begin
        rd_addr    <= rd_addr + ADDR_W'(1);
        issue_left <= issue_left - CNT_W'(1);
      end
      if (kern_rvalid)
      begin
        sum_a     <= sum_a_next;
        sum_b     <= sum_b + sum_a_next;
        recv_left <= recv_left - CNT_W'(1);
      end
      // All words back
      if (recv_left == '0)
      begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  a_ack_only_after_strobe: assert property (@(posedge clk) disable iff (!sync_rst_n)
    reg_ack |-> $past(reg_wr || reg_rd));

  a_addr_held: assert property (@(posedge clk) disable iff (!sync_rst_n)
    (kern_req && !kern_gnt) |=> kern_req && $stable(kern_addr));

  // Returned words always belong to the current run
  a_rvalid_in_run: assert property (@(posedge clk) disable iff (!sync_rst_n)
    kern_rvalid |-> busy && (recv_left != '0));

endmodule

// File: rtl/shell_top.sv
`timescale 1ns/1ps
/* Memory shell: host port and checksum kernel share one word memory
   Register accesses are acked 2 * REG_PIPE_STAGES + 1 cycles after the strobe
   The register path has no back-pressure */
module shell_top (
  input  logic                             clk,
  input  logic                             sync_rst_n,
  // Host memory port
  input  logic                             host_req,
  input  logic                             host_we,
  input  logic [shell_pkg::ADDR_W-1:0]     host_addr,
  input  logic [shell_pkg::DATA_W-1:0]     host_wdata,
  output logic                             host_gnt,
  output logic                             host_rvalid,
  output logic [shell_pkg::DATA_W-1:0]     host_rdata,
  // Register port
  input  logic                             reg_wr,
  input  logic                             reg_rd,
  input  logic [shell_pkg::REG_ADDR_W-1:0] reg_addr,
  input  logic [shell_pkg::DATA_W-1:0]     reg_wdata,
  output logic                             reg_ack,
  output logic [shell_pkg::DATA_W-1:0]     reg_rdata
);
  import shell_pkg::*;

  // Register path at the kernel side of the pipes
  logic                  pipe_reg_wr;
  logic                  pipe_reg_rd;
  logic [REG_ADDR_W-1:0] pipe_reg_addr;
  logic [DATA_W-1:0]     pipe_reg_wdata;
  logic                  kern_reg_ack;
  logic [DATA_W-1:0]     kern_reg_rdata;

  // Kernel memory port
  logic                  kern_req;
  logic [ADDR_W-1:0]     kern_addr;
  logic                  kern_gnt;
  logic                  kern_rvalid;
  logic [DATA_W-1:0]     kern_rdata;

  // Memory
  logic                  mem_en;
  logic                  mem_we;
  logic [ADDR_W-1:0]     mem_addr;
  logic [DATA_W-1:0]     mem_wdata;
  logic [DATA_W-1:0]     mem_rdata;

  // ----------------------------------------------------------------------
  // Register pipes
  // ----------------------------------------------------------------------
  cmd_pipe #(
    .WIDTH  (REQ_PIPE_W),
    .STAGES (REG_PIPE_STAGES)
  ) u_req_pipe (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .in_bus     ({reg_wr, reg_rd, reg_addr, reg_wdata}),
    .out_bus    ({pipe_reg_wr, pipe_reg_rd, pipe_reg_addr, pipe_reg_wdata})
  );

  cmd_pipe #(
    .WIDTH  (RSP_PIPE_W),
    .STAGES (REG_PIPE_STAGES)
  ) u_rsp_pipe (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .in_bus     ({kern_reg_ack, kern_reg_rdata}),
    .out_bus    ({reg_ack, reg_rdata})
  );

  // ----------------------------------------------------------------------
  // Kernel, arbiter and memory
  // ----------------------------------------------------------------------
  fletcher_kernel u_kernel (
    .clk         (clk),
    .sync_rst_n  (sync_rst_n),
    .reg_wr      (pipe_reg_wr),
    .reg_rd      (pipe_reg_rd),
    .reg_addr    (pipe_reg_addr),
    .reg_wdata   (pipe_reg_wdata),
    .reg_ack     (kern_reg_ack),
    .reg_rdata   (kern_reg_rdata),
    .kern_req    (kern_req),
    .kern_addr   (kern_addr),
    .kern_gnt    (kern_gnt),
    .kern_rvalid (kern_rvalid),
    .kern_rdata  (kern_rdata)
  );

  mem_arbiter u_arbiter (
    .clk         (clk),
    .sync_rst_n  (sync_rst_n),
    .host_req    (host_req),
    .host_we     (host_we),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_gnt    (host_gnt),
    .host_rvalid (host_rvalid),
    .host_rdata  (host_rdata),
    .kern_req    (kern_req),
    .kern_addr   (kern_addr),
    .kern_gnt    (kern_gnt),
    .kern_rvalid (kern_rvalid),
    .kern_rdata  (kern_rdata),
    .mem_en      (mem_en),
    .mem_we      (mem_we),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_rdata   (mem_rdata)
  );

  word_memory u_memory (
    .clk       (clk),
    .mem_en    (mem_en),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

endmodule

// File: bench/tb_shell.sv
`timescale 1ns/1ps
/* Testbench for the memory shell, checked against a memory model held here
   Inputs change 1 ns after the rising edge; outputs are sampled at the falling edge
   Ack latency is taken from REG_PIPE_STAGES in the package */
module tb_shell;
  import shell_pkg::*;

  localparam int ACK_LAT       = 2 * REG_PIPE_STAGES + 1;
  localparam int GNT_TIMEOUT   = 64;
  localparam int ACK_TIMEOUT   = 32;
  localparam int DRAIN_TIMEOUT = 16;
  localparam int POLL_LIMIT    = 400;

  logic                  clk;
  logic                  sync_rst_n;
  logic                  host_req;
  logic                  host_we;
  logic [ADDR_W-1:0]     host_addr;
  logic [DATA_W-1:0]     host_wdata;
  logic                  host_gnt;
  logic                  host_rvalid;
  logic [DATA_W-1:0]     host_rdata;
  logic                  reg_wr;
  logic                  reg_rd;
  logic [REG_ADDR_W-1:0] reg_addr;
  logic [DATA_W-1:0]     reg_wdata;
  logic                  reg_ack;
  logic [DATA_W-1:0]     reg_rdata;

  logic [DATA_W-1:0] model [MEM_WORDS];
  logic [DATA_W-1:0] exp_q [$];
  logic [31:0]       lfsr_state;
  logic              read_gnt_seen;
  int                errors;
  int                tests;
  int                test_base;
  int                reads_checked;

  shell_top UUT (
    .clk         (clk),
    .sync_rst_n  (sync_rst_n),
    .host_req    (host_req),
    .host_we     (host_we),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_gnt    (host_gnt),
    .host_rvalid (host_rvalid),
    .host_rdata  (host_rdata),
    .reg_wr      (reg_wr),
    .reg_rd      (reg_rd),
    .reg_addr    (reg_addr),
    .reg_wdata   (reg_wdata),
    .reg_ack     (reg_ack),
    .reg_rdata   (reg_rdata)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // ----------------------------------------------------------------------
  // Random data and reference sums
  // ----------------------------------------------------------------------
  // Galois form with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
    begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    else
    begin
      return s >> 1;
    end
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Word addresses wrap at the end of memory
  function automatic logic [DATA_W-1:0] ref_sum_a(input int start, input int count);
    logic [DATA_W-1:0] a;
    a = '0;
    for (int i = 0; i < count; i++)
    begin
      a = a + model[ADDR_W'(start + i)];
    end
    return a;
  endfunction

  function automatic logic [DATA_W-1:0] ref_sum_b(input int start, input int count);
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    a = '0;
    b = '0;
    for (int i = 0; i < count; i++)
    begin
      a = a + model[ADDR_W'(start + i)];
      b = b + a;
    end
    return b;
  endfunction

  // ----------------------------------------------------------------------
  // Reporting
  // ----------------------------------------------------------------------
  task automatic report_mismatch(input string sig, input logic [DATA_W-1:0] got,
                                 input logic [DATA_W-1:0] exp);
    errors++;
    $display("ERR t=%0t %s got %h expected %h", $time, sig, got, exp);
  endtask

  task automatic report_failure(input string why);
    errors++;
    $display("Failure at t=%0t: %s", $time, why);
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("Test %-12s done, %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  // ----------------------------------------------------------------------
  // Host port
  // ----------------------------------------------------------------------
  // Holds the request until granted, leaves it up for the next caller
  task automatic host_access(input logic we, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] data);
    int waited;
    host_req   = 1'b1;
    host_we    = we;
    host_addr  = addr;
    host_wdata = data;
    waited     = 0;
    @(negedge clk);
    while (!host_gnt && waited < GNT_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!host_gnt)
    begin
      report_failure("host request was not granted within the timeout");
    end
    else if (we)
    begin
      model[addr] = data;
    end
    else
    begin
      exp_q.push_back(model[addr]);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic host_idle();
    host_req = 1'b0;
    host_we  = 1'b0;
  endtask

  task automatic drain_reads();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0)
    begin
      report_failure("host reads did not all return within the timeout");
      exp_q.delete();
    end
    @(posedge clk);
    #1;
  endtask

  task automatic preload(input int start, input int count);
    for (int i = 0; i < count; i++)
    begin
      host_access(1'b1, ADDR_W'(start + i), rand_bits(DATA_W));
    end
    host_idle();
  endtask

  // Each read must match the oldest queued word, one cycle after its grant
  always @(negedge clk)
  begin
    if (sync_rst_n)
    begin
      if (host_rvalid != read_gnt_seen)
      begin
        report_failure("host_rvalid not exactly one cycle after a read grant");
      end
      if (host_rvalid && exp_q.size() == 0)
      begin
        report_failure("host_rvalid with no read outstanding");
      end
      else if (host_rvalid)
      begin
        reads_checked++;
        if (host_rdata !== exp_q[0])
        begin
          report_mismatch("host_rdata", host_rdata, exp_q[0]);
        end
        void'(exp_q.pop_front());
      end
    end
    read_gnt_seen = host_gnt && host_req && !host_we;
  end

  // ----------------------------------------------------------------------
  // Register port
  // ----------------------------------------------------------------------
  task automatic reg_access(input logic wr, input logic [REG_ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata,
                            output logic [DATA_W-1:0] rdata);
    int lat;
    reg_wr    = wr;
    reg_rd    = !wr;
    reg_addr  = addr;
    reg_wdata = wdata;
    @(posedge clk);
    #1;
    reg_wr = 1'b0;
    reg_rd = 1'b0;
    lat    = 1;
    @(negedge clk);
    while (!reg_ack && lat < ACK_TIMEOUT)
    begin
      @(negedge clk);
      lat++;
    end
    if (!reg_ack)
    begin
      report_failure("register access got no ack within the timeout");
    end
    else
    begin
      if (lat != ACK_LAT)
      begin
        report_mismatch("reg_ack latency", DATA_W'(lat), DATA_W'(ACK_LAT));
      end
      if (wr && reg_rdata !== '0)
      begin
        report_mismatch("reg_rdata", reg_rdata, '0);
      end
    end
    rdata = reg_rdata;
    @(posedge clk);
    #1;
  endtask

  task automatic reg_write(input logic [REG_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] ignored;
    reg_access(1'b1, addr, data, ignored);
  endtask

  task automatic reg_read(input logic [REG_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    reg_access(1'b0, addr, '0, data);
  endtask

  // Start a run, poll STATUS for done, then compare both sums
  task automatic run_kernel(input int start, input int count);
    logic [DATA_W-1:0] rd;
    int polls;
    reg_write(REG_START_ADDR, DATA_W'(start));
    reg_write(REG_WORD_COUNT, DATA_W'(count));
    reg_write(REG_CTRL, DATA_W'(1) << CTRL_START_BIT);
    polls = 0;
    reg_read(REG_STATUS, rd);
    while (!rd[STATUS_DONE_BIT] && polls < POLL_LIMIT)
    begin
      reg_read(REG_STATUS, rd);
      polls++;
    end
    if (!rd[STATUS_DONE_BIT])
    begin
      report_failure("kernel did not report done within the poll limit");
    end
    else
    begin
      if (rd[STATUS_BUSY_BIT])
      begin
        report_failure("kernel busy still set together with done");
      end
      reg_read(REG_SUM_A, rd);
      if (rd !== ref_sum_a(start, count))
      begin
        report_mismatch("sum_a", rd, ref_sum_a(start, count));
      end
      reg_read(REG_SUM_B, rd);
      if (rd !== ref_sum_b(start, count))
      begin
        report_mismatch("sum_b", rd, ref_sum_b(start, count));
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial
  begin
    logic [DATA_W-1:0] rd;
    logic [ADDR_W-1:0] addr_list [32];
    sync_rst_n    = 1'b0;
    host_req      = 1'b0;
    host_we       = 1'b0;
    host_addr     = '0;
    host_wdata    = '0;
    reg_wr        = 1'b0;
    reg_rd        = 1'b0;
    reg_addr      = '0;
    reg_wdata     = '0;
    lfsr_state    = 32'h9fc9b651;
    read_gnt_seen = 1'b0;
    errors        = 0;
    tests         = 0;
    test_base     = 0;
    reads_checked = 0;

    // Five cycles in reset and two more watched after release
    for (int i = 0; i < 7; i++)
    begin
      @(negedge clk);
      if (host_gnt || host_rvalid || reg_ack)
      begin
        report_failure("an output was active during or right after reset");
      end
      if (i == 4)
      begin
        @(posedge clk);
        #1;
        sync_rst_n = 1'b1;
      end
    end
    @(posedge clk);
    #1;
    reg_read(REG_STATUS, rd);
    if (rd !== '0)
    begin
      report_mismatch("status", rd, '0);
    end
    finish_test("reset");

    // Random writes, then back-to-back reads of the same addresses
    for (int i = 0; i < 32; i++)
    begin
      addr_list[i] = ADDR_W'(rand_bits(ADDR_W));
      host_access(1'b1, addr_list[i], rand_bits(DATA_W));
    end
    for (int i = 0; i < 32; i++)
    begin
      host_access(1'b0, addr_list[i], '0);
    end
    host_idle();
    drain_reads();
    finish_test("host_memory");

    reg_write(REG_START_ADDR, 32'h0000_0155);
    reg_read(REG_START_ADDR, rd);
    if (rd !== 32'h0000_0155)
    begin
      report_mismatch("start_addr", rd, 32'h0000_0155);
    end
    reg_write(REG_START_ADDR, 32'hFFFF_F3A5);
    reg_read(REG_START_ADDR, rd);
    if (rd !== (32'hFFFF_F3A5 & DATA_W'(MEM_WORDS - 1)))
    begin
      report_mismatch("start_addr", rd, 32'hFFFF_F3A5 & DATA_W'(MEM_WORDS - 1));
    end
    reg_write(REG_WORD_COUNT, 32'h0000_002A);
    reg_read(REG_WORD_COUNT, rd);
    if (rd !== 32'h0000_002A)
    begin
      report_mismatch("word_count", rd, 32'h0000_002A);
    end
    reg_read(8'h20, rd);
    if (rd !== '0)
    begin
      report_mismatch("unmapped 0x20", rd, '0);
    end
    finish_test("registers");

    // Plain range, a range wrapping past the top, and an empty range
    preload(40, 64);
    run_kernel(40, 64);
    preload(1000, 60);
    run_kernel(1000, 60);
    run_kernel(500, 0);
    finish_test("kernel_run");

    // Host traffic kept clear of the kernel's range while it runs
    preload(100, 200);
    fork
      run_kernel(100, 200);
      begin
        for (int i = 0; i < 96; i++)
        begin
          host_access(1'b1, ADDR_W'(512 + i), rand_bits(DATA_W));
          host_access(1'b0, ADDR_W'(512 + i), '0);
        end
        host_idle();
        drain_reads();
      end
    join
    finish_test("contention");

    $display("Summary: %0d tests, %0d host reads checked, %0d errors",
             tests, reads_checked, errors);
    if (errors == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: vlog.f
rtl/shell_pkg.sv
rtl/cmd_pipe.sv
rtl/word_memory.sv
rtl/mem_arbiter.sv
rtl/fletcher_kernel.sv
rtl/shell_top.sv
bench/tb_shell.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the shell testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_shell -f vlog.f -o tb_shell
./obj_dir/tb_shell > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation PASSED"
exit 0
